//--- tb.f
+incdir+include
source/dbg_pkg.sv
source/dbg_access_ctrl.sv
source/dbg_regs.sv
source/dbg_bp_match.sv
source/dbg_cause_enc.sv
source/debug_unit.sv
verification/tb_debug_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the debug unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_debug_unit -o sim_tb_debug_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_debug_unit > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi
exit 0

//--- verification/tb_debug_unit.sv
/*
 * Debug unit testbench
 * Register access and handshake timing, fetch and memory breakpoints,
 * instruction and branch breaks, cause recording, stalls and
 * accesses outside the internal bank
 */
`timescale 1ns/1ps
`include "dbg_cfg.svh"

module tb_debug_unit
  import dbg_pkg::*;
();

  // About four times the length of the full test sequence
  localparam int max_cycles = 2000;

  logic      clk;
  logic      rstn;
  logic      dbg_stall;
  logic      dbg_strb;
  logic      dbg_we;
  dbg_addr_t dbg_addr;
  xlen_t     dbg_dati;
  xlen_t     dbg_dato;
  logic      dbg_ack;
  logic      dbg_bp;
  logic      du_stall;
  xlen_t     du_ie;
  xlen_t     if_pc;
  instr_t    if_instr;
  logic      if_bubble;
  instr_t    mem_instr;
  logic      mem_bubble;
  logic      mem_exception;
  xlen_t     mem_memadr;
  logic      dmem_ack;
  logic      ex_stall;
  exc_vec_t  du_exceptions;
  logic [4:0] opcs [3];
  int        cycles = 0;

  debug_unit DUT (.*);

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and checks
  //////////////////////////////////////////////////////////////////////
  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input xlen_t got, input xlen_t exp);
    fail_run($sformatf("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h",
                       $time, name, got, exp));
  endtask

  task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
    assert (got === exp) else report_mismatch(name, got, exp);
  endtask

  ack_one_cycle: assert property (@(posedge clk) disable iff (!rstn) dbg_ack |=> !dbg_ack)
    else report_mismatch("dbg_ack", 32'd1, 32'd0);

  bp_held_by_stall: assert property (@(posedge clk) disable iff (!rstn) dbg_stall |=> !dbg_bp)
    else report_mismatch("dbg_bp", 32'd1, 32'd0);

  //////////////////////////////////////////////////////////////////////
  // Clock, run limit and expected values
  //////////////////////////////////////////////////////////////////////
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) fail_run("Timeout: test did not finish within the cycle limit");
  end

  function automatic dbg_ofs_t bpctrl_ofs(input int n);
    return dbg_ofs_t'(`DBG_BPCTRL0 + 2 * n);
  endfunction

  function automatic dbg_ofs_t bpdata_ofs(input int n);
    return dbg_ofs_t'(`DBG_BPDATA0 + 2 * n);
  endfunction

  // Lowest trap wins, else lowest interrupt with the top bit set
  function automatic xlen_t expected_cause(input exc_vec_t vec);
    int idx;
    idx = 0;
    if (vec[15:0] != 16'd0) begin
      while (!vec[idx]) idx++;
      return xlen_t'(idx);
    end
    while (!vec[16 + idx]) idx++;
    return {1'b1, 31'(idx)};
  endfunction

  function automatic logic mem_should_hit(input bp_cc_t cc, input logic [4:0] opc);
    logic ld;
    logic st;
    logic hit;
    ld  = opc == `OPC_LOAD;
    st  = opc == `OPC_STORE;
    hit = 1'b0;
    case (cc)
      `BP_CC_LD_ADR:   hit = ld;
      `BP_CC_ST_ADR:   hit = st;
      `BP_CC_LDST_ADR: hit = ld || st;
      default:         hit = 1'b0;
    endcase
    return hit;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Debugger and pipeline stimulus
  //////////////////////////////////////////////////////////////////////
  // Starts on a falling edge and holds ex_stall for the given number of cycles
  task automatic bus_access(input logic we, input dbg_addr_t addr, input xlen_t wdata,
                            input int stall, output xlen_t rdata);
    int waited;
    waited   = 0;
    dbg_strb = 1'b1;
    dbg_we   = we;
    dbg_addr = addr;
    dbg_dati = wdata;
    ex_stall = 1'b0;
    do begin
      @(negedge clk);
      waited++;
      ex_stall = waited <= stall;
    end while (!dbg_ack);
    check_value("dbg_ack cycles", waited, stall + 2);
    rdata    = dbg_dato;
    dbg_strb = 1'b0;
    dbg_we   = 1'b0;
    // Exceptions presented during an access end with it
    du_exceptions = '0;
    // One cycle in ACK and one in WAIT before the next strobe
    repeat (2) @(negedge clk);
  endtask

  task automatic write_reg(input dbg_ofs_t ofs, input xlen_t data);
    xlen_t unused;
    bus_access(1'b1, {4'(`DBG_BANK_INTERNAL), ofs}, data, 0, unused);
  endtask

  task automatic check_reg(input string name, input dbg_ofs_t ofs, input xlen_t exp);
    xlen_t got;
    bus_access(1'b0, {4'(`DBG_BANK_INTERNAL), ofs}, '0, 0, got);
    check_value(name, got, exp);
  endtask

  task automatic fetch(input xlen_t pc, input instr_t instr);
    if_pc     = pc;
    if_instr  = instr;
    if_bubble = 1'b0;
    @(negedge clk);
    if_bubble = 1'b1;
  endtask

  task automatic mem_access(input logic [4:0] opc, input xlen_t adr, input logic ack,
                            input logic bubble, input logic exc);
    mem_instr     = {25'd0, opc, 2'b11};
    mem_memadr    = adr;
    dmem_ack      = ack;
    mem_bubble    = bubble;
    mem_exception = exc;
    @(negedge clk);
    dmem_ack      = 1'b0;
    mem_bubble    = 1'b1;
    mem_exception = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    xlen_t    r;
    xlen_t    got;
    xlen_t    addr;
    exc_vec_t vec;
    bp_cc_t   cc;

    void'($urandom(89));
    opcs          = '{`OPC_LOAD, `OPC_STORE, `OPC_BRANCH};
    rstn          = 1'b0;
    dbg_stall     = 1'b0;
    dbg_strb      = 1'b0;
    dbg_we        = 1'b0;
    dbg_addr      = '0;
    dbg_dati      = '0;
    if_pc         = '0;
    if_instr      = '0;
    if_bubble     = 1'b1;
    mem_instr     = '0;
    mem_bubble    = 1'b1;
    mem_exception = 1'b0;
    mem_memadr    = '0;
    dmem_ack      = 1'b0;
    ex_stall      = 1'b0;
    du_exceptions = '0;
    repeat (10) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);

    // Reset values and register read-back
    check_value("dbg_ack", dbg_ack, 0);
    check_value("dbg_bp", dbg_bp, 0);
    check_value("du_ie", du_ie, 0);
    check_value("dbg_dato", dbg_dato, 0);
    check_reg("CTRL", `DBG_CTRL, 0);
    check_reg("HIT", `DBG_HIT, 0);
    check_reg("IE", `DBG_IE, 0);
    check_reg("CAUSE", `DBG_CAUSE, 0);
    for (int n = 0; n < `DBG_BREAKPOINTS; n++) begin
      check_reg("BPCTRL", bpctrl_ofs(n), 32'h1);
      check_reg("BPDATA", bpdata_ofs(n), 0);
    end
    r = $urandom;
    write_reg(`DBG_CTRL, r);
    check_reg("CTRL", `DBG_CTRL, r & 32'h3);
    write_reg(`DBG_CTRL, 0);
    r = $urandom;
    write_reg(`DBG_IE, r);
    check_reg("IE", `DBG_IE, r);
    check_value("du_ie", du_ie, r);
    r = $urandom;
    write_reg(`DBG_CAUSE, r);
    check_reg("CAUSE", `DBG_CAUSE, r);
    for (int n = 0; n < `DBG_BREAKPOINTS; n++) begin
      r = $urandom;
      write_reg(bpdata_ofs(n), r);
      check_reg("BPDATA", bpdata_ofs(n), r);
      r = $urandom;
      write_reg(bpctrl_ofs(n), r);
      check_reg("BPCTRL", bpctrl_ofs(n), (r & 32'h72) | 32'h1);
    end

    // Fetch breakpoints, enabled then disabled
    for (int n = 0; n < `DBG_BREAKPOINTS; n++) begin
      addr = $urandom;
      write_reg(bpdata_ofs(n), addr);
      write_reg(bpctrl_ofs(n), 32'h2);
      fetch(addr ^ 32'h4, 32'h13);
      fetch(addr, 32'h13);
      check_value("dbg_bp", dbg_bp, 0);
      @(negedge clk);
      check_value("dbg_bp", dbg_bp, 1);
      check_reg("HIT", `DBG_HIT, 32'h10 << n);
      write_reg(`DBG_HIT, 0);
      check_value("dbg_bp", dbg_bp, 0);
      write_reg(bpctrl_ofs(n), 32'h0);
      fetch(addr, 32'h13);
      check_reg("HIT", `DBG_HIT, 0);
    end

    // Load, store and load/store address conditions on breakpoint 1
    addr = $urandom;
    write_reg(bpdata_ofs(1), addr);
    for (int c = 1; c <= 3; c++) begin
      cc = bp_cc_t'(c);
      write_reg(bpctrl_ofs(1), {25'd0, cc, 4'b0010});
      for (int k = 0; k < 3; k++) begin
        mem_access(opcs[k], addr, 1'b1, 1'b0, 1'b0);
        check_reg("HIT", `DBG_HIT, xlen_t'(mem_should_hit(cc, opcs[k])) << 5);
        write_reg(`DBG_HIT, 0);
      end
    end
    mem_access(`OPC_LOAD, addr, 1'b0, 1'b0, 1'b0);
    mem_access(`OPC_LOAD, addr, 1'b1, 1'b1, 1'b0);
    mem_access(`OPC_LOAD, addr, 1'b1, 1'b0, 1'b1);
    mem_access(`OPC_STORE, addr ^ 32'h100, 1'b1, 1'b0, 1'b0);
    check_reg("HIT", `DBG_HIT, 0);
    write_reg(bpctrl_ofs(1), 0);

    // Instruction break on any fetch, branch break on branches only
    write_reg(`DBG_CTRL, 32'h1);
    fetch($urandom, $urandom);
    check_reg("HIT", `DBG_HIT, 32'h1);
    write_reg(`DBG_CTRL, 32'h2);
    write_reg(`DBG_HIT, 0);
    fetch($urandom, 32'h13);
    check_reg("HIT", `DBG_HIT, 0);
    fetch($urandom, 32'h63);
    check_reg("HIT", `DBG_HIT, 32'h2);
    write_reg(`DBG_CTRL, 0);
    write_reg(`DBG_HIT, 0);

    // Traps, then interrupts alone
    for (int i = 0; i < 8; i++) begin
      if (i < 4) begin
        vec = $urandom;
        vec[$urandom % 16] = 1'b1;
      end else begin
        vec = $urandom & 32'hffff_0000;
        vec[16 + $urandom % 16] = 1'b1;
      end
      du_exceptions = vec;
      @(negedge clk);
      du_exceptions = '0;
      check_value("dbg_bp", dbg_bp, 1);
      check_reg("CAUSE", `DBG_CAUSE, expected_cause(vec));
    end
    r = $urandom;
    du_exceptions = 32'h0000_0100;
    write_reg(`DBG_CAUSE, r);
    check_reg("CAUSE", `DBG_CAUSE, r);

    // Stalled accesses
    for (int k = 1; k <= 3; k++) begin
      r = $urandom;
      bus_access(1'b1, {4'h0, `DBG_IE}, r, k, got);
      bus_access(1'b0, {4'h0, `DBG_IE}, '0, k, got);
      check_value("IE", got, r);
    end

    // dbg_stall holds back dbg_bp
    dbg_stall = 1'b1;
    write_reg(`DBG_HIT, 32'h1);
    check_value("du_stall", du_stall, 1);
    repeat (3) @(negedge clk);
    check_value("dbg_bp", dbg_bp, 0);
    dbg_stall = 1'b0;
    @(negedge clk);
    check_value("dbg_bp", dbg_bp, 1);
    check_value("du_stall", du_stall, 0);

    // A stalled execute stage holds back dbg_bp as well
    ex_stall = 1'b1;
    @(negedge clk);
    check_value("dbg_bp", dbg_bp, 0);
    ex_stall = 1'b0;
    write_reg(`DBG_HIT, 0);

    // Bank 1 is not implemented
    bus_access(1'b1, 16'h1002, $urandom, 0, got);
    bus_access(1'b0, 16'h1002, '0, 0, got);
    check_value("dbg_dato", got, 0);
    check_reg("IE", `DBG_IE, r);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- source/debug_unit.sv
/*
 * RISC-V debug unit
 * Debugger register access, hardware breakpoints on fetch and
 * memory stage, sticky hits and exception cause recording
 */
`timescale 1ns/1ps

module debug_unit
  import dbg_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,

  // Debugger port
  input  logic      dbg_stall,
  input  logic      dbg_strb,
  input  logic      dbg_we,
  input  dbg_addr_t dbg_addr,
  input  xlen_t     dbg_dati,
  output xlen_t     dbg_dato,
  output logic      dbg_ack,
  output logic      dbg_bp,

  // To the core
  output logic      du_stall,
  output xlen_t     du_ie,

  // Pipeline observation
  input  xlen_t     if_pc,
  input  instr_t    if_instr,
  input  logic      if_bubble,
  input  instr_t    mem_instr,
  input  logic      mem_bubble,
  input  logic      mem_exception,
  input  xlen_t     mem_memadr,
  input  logic      dmem_ack,
  input  logic      ex_stall,
  input  exc_vec_t  du_exceptions
);

  logic     wr_en;
  logic     rd_capture;
  logic     in_bank;
  dbg_ofs_t reg_ofs;
  xlen_t    wr_data;
  xlen_t    bp_rdata;
  bp_vec_t  bp_hit;
  logic     instr_hit;
  logic     branch_hit;
  logic     instr_break_ena;
  logic     branch_break_ena;
  xlen_t    exc_cause;
  logic     exc_any;

  assign du_stall = dbg_stall;

  dbg_access_ctrl u_access_ctrl (
    .clk        (clk),
    .rstn       (rstn),
    .dbg_strb   (dbg_strb),
    .dbg_we     (dbg_we),
    .dbg_addr   (dbg_addr),
    .dbg_dati   (dbg_dati),
    .ex_stall   (ex_stall),
    .dbg_ack    (dbg_ack),
    .wr_en      (wr_en),
    .rd_capture (rd_capture),
    .reg_ofs    (reg_ofs),
    .wr_data    (wr_data),
    .in_bank    (in_bank)
  );

  dbg_regs u_regs (
    .clk              (clk),
    .rstn             (rstn),
    .wr_en            (wr_en),
    .rd_capture       (rd_capture),
    .in_bank          (in_bank),
    .reg_ofs          (reg_ofs),
    .wr_data          (wr_data),
    .bp_rdata         (bp_rdata),
    .bp_hit           (bp_hit),
    .instr_hit        (instr_hit),
    .branch_hit       (branch_hit),
    .exc_cause        (exc_cause),
    .exc_any          (exc_any),
    .du_exceptions    (du_exceptions),
    .ex_stall         (ex_stall),
    .dbg_stall        (dbg_stall),
    .dbg_dato         (dbg_dato),
    .dbg_bp           (dbg_bp),
    .du_ie            (du_ie),
    .instr_break_ena  (instr_break_ena),
    .branch_break_ena (branch_break_ena)
  );

  dbg_bp_match u_bp_match (
    .clk              (clk),
    .rstn             (rstn),
    .wr_en            (wr_en),
    .reg_ofs          (reg_ofs),
    .wr_data          (wr_data),
    .instr_break_ena  (instr_break_ena),
    .branch_break_ena (branch_break_ena),
    .if_pc            (if_pc),
    .if_instr         (if_instr),
    .if_bubble        (if_bubble),
    .mem_instr        (mem_instr),
    .mem_bubble       (mem_bubble),
    .mem_exception    (mem_exception),
    .mem_memadr       (mem_memadr),
    .dmem_ack         (dmem_ack),
    .bp_rdata         (bp_rdata),
    .bp_hit           (bp_hit),
    .instr_hit        (instr_hit),
    .branch_hit       (branch_hit)
  );

  dbg_cause_enc u_cause_enc (
    .du_exceptions (du_exceptions),
    .exc_cause     (exc_cause),
    .exc_any       (exc_any)
  );

endmodule

//--- source/dbg_cause_enc.sv
/*
 * Exception cause encoder
 * The lowest pending trap gives its index, otherwise the lowest
 * pending interrupt gives its index with the top bit set
 */
`timescale 1ns/1ps
`include "dbg_cfg.svh"

module dbg_cause_enc
  import dbg_pkg::*;
(
  input  exc_vec_t du_exceptions,
  output xlen_t    exc_cause,
  output logic     exc_any
);

  localparam int trap_bits = 16;

  logic trap_any;
  logic irq_any;

  assign trap_any = |du_exceptions[trap_bits-1:0];
  assign irq_any  = |du_exceptions[31:trap_bits];
  assign exc_any  = trap_any || irq_any;

  always_comb begin
    exc_cause = '0;
    if (trap_any) begin
      // Scan downward so the lowest bit is left
      for (int i = trap_bits - 1; i >= 0; i--) begin
        if (du_exceptions[i]) exc_cause = xlen_t'(i);
      end
    end else if (irq_any) begin
      for (int j = trap_bits - 1; j >= 0; j--) begin
        if (du_exceptions[trap_bits+j]) exc_cause = xlen_t'(j);
      end
      exc_cause[`DBG_XLEN-1] = 1'b1;
    end
  end

endmodule

//--- source/dbg_bp_match.sv
/*
 * Hardware breakpoints
 * Control and data registers per breakpoint, the fetch and memory
 * address comparators, and the instruction and branch break hits
 */
`timescale 1ns/1ps
`include "dbg_cfg.svh"

module dbg_bp_match
  import dbg_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     wr_en,
  input  dbg_ofs_t reg_ofs,
  input  xlen_t    wr_data,
  input  logic     instr_break_ena,
  input  logic     branch_break_ena,
  input  xlen_t    if_pc,
  input  instr_t   if_instr,
  input  logic     if_bubble,
  input  instr_t   mem_instr,
  input  logic     mem_bubble,
  input  logic     mem_exception,
  input  xlen_t    mem_memadr,
  input  logic     dmem_ack,
  output xlen_t    bp_rdata,
  output bp_vec_t  bp_hit,
  output logic     instr_hit,
  output logic     branch_hit
);

  bp_vec_t bp_ena;
  bp_cc_t  bp_cc   [`DBG_BREAKPOINTS];
  xlen_t   bp_data [`DBG_BREAKPOINTS];
  logic    mem_ok;
  logic    mem_read;
  logic    mem_write;

  // Breakpoint n sits at base + 2n
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bp_ena <= '0;
      for (int n = 0; n < `DBG_BREAKPOINTS; n++) begin
        bp_cc[n]   <= '0;
        bp_data[n] <= '0;
      end
    end else if (wr_en) begin
      for (int n = 0; n < `DBG_BREAKPOINTS; n++) begin
        if (reg_ofs == dbg_ofs_t'(`DBG_BPCTRL0 + 2 * n)) begin
          bp_ena[n] <= wr_data[1];
          bp_cc[n]  <= wr_data[6:4];
        end
        if (reg_ofs == dbg_ofs_t'(`DBG_BPDATA0 + 2 * n)) begin
          bp_data[n] <= wr_data;
        end
      end
    end
  end

  // Control read-back with bit 0 as the implemented flag
  always_comb begin
    bp_rdata = '0;
    for (int n = 0; n < `DBG_BREAKPOINTS; n++) begin
      if (reg_ofs == dbg_ofs_t'(`DBG_BPCTRL0 + 2 * n)) begin
        bp_rdata[6:4] = bp_cc[n];
        bp_rdata[1]   = bp_ena[n];
        bp_rdata[0]   = 1'b1;
      end
      if (reg_ofs == dbg_ofs_t'(`DBG_BPDATA0 + 2 * n)) begin
        bp_rdata = bp_data[n];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Match logic
  //////////////////////////////////////////////////////////////////////
  assign mem_ok    = dmem_ack && !mem_bubble && !mem_exception;
  assign mem_read  = mem_ok && mem_instr[6:2] == `OPC_LOAD;
  assign mem_write = mem_ok && mem_instr[6:2] == `OPC_STORE;

  always_comb begin
    for (int n = 0; n < `DBG_BREAKPOINTS; n++) begin
      case (bp_cc[n])
        `BP_CC_FETCH:    bp_hit[n] = !if_bubble && if_pc == bp_data[n];
        `BP_CC_LD_ADR:   bp_hit[n] = mem_read && mem_memadr == bp_data[n];
        `BP_CC_ST_ADR:   bp_hit[n] = mem_write && mem_memadr == bp_data[n];
        `BP_CC_LDST_ADR: bp_hit[n] = (mem_read || mem_write) && mem_memadr == bp_data[n];
        default:         bp_hit[n] = 1'b0;
      endcase
      bp_hit[n] = bp_hit[n] && bp_ena[n];
    end
  end

  // Single-step style breaks on the fetch stage
  assign instr_hit  = instr_break_ena && !if_bubble;
  assign branch_hit = branch_break_ena && !if_bubble && if_instr[6:2] == `OPC_BRANCH;

endmodule

//--- source/dbg_regs.sv
/*
 * Debug register file
 * Control, sticky hit, interrupt-enable and cause registers, the
 * debugger read-data register and the registered breakpoint output
 */
`timescale 1ns/1ps
`include "dbg_cfg.svh"

module dbg_regs
  import dbg_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     wr_en,
  input  logic     rd_capture,
  input  logic     in_bank,
  input  dbg_ofs_t reg_ofs,
  input  xlen_t    wr_data,
  input  xlen_t    bp_rdata,
  input  bp_vec_t  bp_hit,
  input  logic     instr_hit,
  input  logic     branch_hit,
  input  xlen_t    exc_cause,
  input  logic     exc_any,
  input  exc_vec_t du_exceptions,
  input  logic     ex_stall,
  input  logic     dbg_stall,
  output xlen_t    dbg_dato,
  output logic     dbg_bp,
  output xlen_t    du_ie,
  output logic     instr_break_ena,
  output logic     branch_break_ena
);

  logic    instr_hit_q;
  logic    branch_hit_q;
  bp_vec_t bp_hit_q;
  xlen_t   ie_q;
  xlen_t   cause_q;
  xlen_t   hit_word;
  xlen_t   rdata;

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      instr_break_ena  <= 1'b0;
      branch_break_ena <= 1'b0;
    end else if (wr_en && reg_ofs == `DBG_CTRL) begin
      instr_break_ena  <= wr_data[0];
      branch_break_ena <= wr_data[1];
    end
  end

  // A HIT write replaces all sticky flags
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      instr_hit_q  <= 1'b0;
      branch_hit_q <= 1'b0;
      bp_hit_q     <= '0;
    end else if (wr_en && reg_ofs == `DBG_HIT) begin
      instr_hit_q  <= wr_data[0];
      branch_hit_q <= wr_data[1];
      bp_hit_q     <= wr_data[4 +: `DBG_BREAKPOINTS];
    end else begin
      instr_hit_q  <= instr_hit_q | instr_hit;
      branch_hit_q <= branch_hit_q | branch_hit;
      bp_hit_q     <= bp_hit_q | bp_hit;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ie_q <= '0;
    end else if (wr_en && reg_ofs == `DBG_IE) begin
      ie_q <= wr_data;
    end
  end

  // Debugger write wins over a new cause
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cause_q <= '0;
    end else if (wr_en && reg_ofs == `DBG_CAUSE) begin
      cause_q <= wr_data;
    end else if (exc_any) begin
      cause_q <= exc_cause;
    end
  end

  assign du_ie = ie_q;

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    hit_word                        = '0;
    hit_word[0]                     = instr_hit_q;
    hit_word[1]                     = branch_hit_q;
    hit_word[4 +: `DBG_BREAKPOINTS] = bp_hit_q;
  end

  always_comb begin
    case (reg_ofs)
      `DBG_CTRL:  rdata = {{(`DBG_XLEN-2){1'b0}}, branch_break_ena, instr_break_ena};
      `DBG_HIT:   rdata = hit_word;
      `DBG_IE:    rdata = ie_q;
      `DBG_CAUSE: rdata = cause_q;
      // Breakpoint block decodes its own offsets
      default:    rdata = bp_rdata;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dbg_dato <= '0;
    end else if (rd_capture) begin
      dbg_dato <= in_bank ? rdata : '0;
    end
  end

  // Breakpoint to the debugger
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dbg_bp <= 1'b0;
    end else begin
      dbg_bp <= !ex_stall && !dbg_stall && ((|hit_word) || (|du_exceptions));
    end
  end

endmodule

//--- source/dbg_access_ctrl.sv
/*
 * Debugger access controller
 * Latches a strobed access, decodes the register bank, issues the
 * write and read-capture strobes once the pipeline is not stalled
 * and returns a one-cycle acknowledge
 */
`timescale 1ns/1ps
`include "dbg_cfg.svh"

module dbg_access_ctrl
  import dbg_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      dbg_strb,
  input  logic      dbg_we,
  input  dbg_addr_t dbg_addr,
  input  xlen_t     dbg_dati,
  input  logic      ex_stall,
  output logic      dbg_ack,
  output logic      wr_en,
  output logic      rd_capture,
  output dbg_ofs_t  reg_ofs,
  output xlen_t     wr_data,
  output logic      in_bank
);

  acc_state_t state;
  dbg_ofs_t   ofs_q;
  xlen_t      data_q;
  logic       we_q;
  logic       bank_q;
  logic       do_access;

  //////////////////////////////////////////////////////////////////////
  // Access state machine
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= ACC_IDLE;
    end else begin
      case (state)
        ACC_IDLE: if (dbg_strb) state <= ACC_BUSY;
        // Stalled pipeline holds the access here
        ACC_BUSY: if (!ex_stall) state <= ACC_ACK;
        ACC_ACK:  state <= ACC_WAIT;
        ACC_WAIT: if (!dbg_strb) state <= ACC_IDLE;
        default:  state <= ACC_IDLE;
      endcase
    end
  end

  // Access capture
  always_ff @(posedge clk) begin
    if (state == ACC_IDLE && dbg_strb) begin
      ofs_q  <= dbg_addr[`DBG_OFS_SIZE-1:0];
      data_q <= dbg_dati;
      we_q   <= dbg_we;
      bank_q <= dbg_addr[`DBG_PLEN-1:`DBG_OFS_SIZE] == `DBG_BANK_INTERNAL;
    end
  end

  assign do_access  = (state == ACC_BUSY) && !ex_stall;

  // Only internal-bank writes reach the registers
  assign wr_en      = do_access && we_q && bank_q;
  assign rd_capture = do_access;
  assign dbg_ack    = state == ACC_ACK;

  assign reg_ofs    = ofs_q;
  assign wr_data    = data_q;
  assign in_bank    = bank_q;

endmodule

//--- source/dbg_pkg.sv
/*
 * Debug unit types
 * Vector types for data, addresses, offsets and breakpoint fields,
 * and the state encoding of the debugger access controller
 */
`include "dbg_cfg.svh"

package dbg_pkg;

  typedef logic [`DBG_XLEN-1:0]        xlen_t;
  typedef logic [`DBG_PLEN-1:0]        dbg_addr_t;
  typedef logic [`DBG_OFS_SIZE-1:0]    dbg_ofs_t;
  typedef logic [2:0]                  bp_cc_t;
  typedef logic [`DBG_BREAKPOINTS-1:0] bp_vec_t;
  // Traps in 15:0, interrupts in 31:16
  typedef logic [31:0]                 exc_vec_t;
  typedef logic [31:0]                 instr_t;

  typedef enum logic [1:0] {
    ACC_IDLE,
    ACC_BUSY,
    ACC_ACK,
    ACC_WAIT
  } acc_state_t;

endpackage

//--- include/dbg_cfg.svh
/*
 * Debug unit configuration
 * Port widths, breakpoint count, internal register offsets,
 * breakpoint condition codes and RISC-V opcode fields
 */
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// Widths
`define DBG_XLEN          32
`define DBG_PLEN          16
`define DBG_OFS_SIZE      12
`define DBG_BANK_INTERNAL 0
`define DBG_BREAKPOINTS   4

// Internal register offsets
`define DBG_CTRL    12'h000
`define DBG_HIT     12'h001
`define DBG_IE      12'h002
`define DBG_CAUSE   12'h003
`define DBG_BPCTRL0 12'h010
`define DBG_BPDATA0 12'h011

// Breakpoint condition codes
`define BP_CC_FETCH    3'd0
`define BP_CC_LD_ADR   3'd1
`define BP_CC_ST_ADR   3'd2
`define BP_CC_LDST_ADR 3'd3

// Instruction bits 6:2
`define OPC_LOAD   5'b00000
`define OPC_STORE  5'b01000
`define OPC_BRANCH 5'b11000

`endif
